/* hdl/face_detect_pkg.sv */
// face detector shared types, block geometry and intake state encoding
package face_detect_pkg;

	//////////////////////////////////////////////////
	// data widths
	//////////////////////////////////////////////////

	typedef logic [11:0] pixel_t;               // grey-scale sample
	typedef logic [15:0] block_sum_t;           // 16 x 4095 fits
	typedef logic signed [16:0] edge_diff_t;    // bottom half minus top half
	typedef logic [7:0] block_coord_t;          // block column or row index
	typedef logic [15:0] face_count_t;          // candidates per frame

	//////////////////////////////////////////////////
	// block geometry
	//////////////////////////////////////////////////

	// the half split and every sum width above assume this value
	localparam int BLOCK_SIZE = 4;

	//////////////////////////////////////////////////
	// intake FSM
	//////////////////////////////////////////////////

	typedef enum logic [1:0]
	{
		IDLE,           // out of reset
		RECEIVE,        // accepting pixels
		FRAME_FLUSH     // waiting for the last block to drain
	} intake_state_t;

endpackage

/* hdl/pixel_intake.sv */
// pixel intake with ready control, raster counters and per-block position strobes
module pixel_intake #(
	parameter int IMG_WIDTH  = 16,
	parameter int IMG_HEIGHT = 16
) (
	input  logic                          clk,
	input  logic                          trig_reset,
	input  face_detect_pkg::pixel_t       pixel,
	input  logic                          end_recieve_pixel,
	output logic                          ready_recieve_pixel,
	output face_detect_pkg::pixel_t       pixel_d,
	output logic                          pixel_strobe,
	output face_detect_pkg::block_coord_t block_col,
	output face_detect_pkg::block_coord_t block_row,
	output logic                          lower_half,
	output logic                          block_start,
	output logic                          block_done,
	output logic                          frame_done
);
	import face_detect_pkg::*;

	localparam int COL_W        = $clog2(IMG_WIDTH);
	localparam int ROW_W        = $clog2(IMG_HEIGHT);
	localparam int BLK_W        = $clog2(BLOCK_SIZE);
	localparam int FLUSH_CYCLES = 3;    // matches the block pipeline depth

	intake_state_t    state;
	logic [COL_W-1:0] col_cnt;
	logic [ROW_W-1:0] row_cnt;
	logic [1:0]       flush_cnt;
	logic [BLK_W-1:0] blk_x;
	logic [BLK_W-1:0] blk_y;
	logic             accept;
	logic             last_col;
	logic             last_row;
	logic             first_in_block;
	logic             last_in_block;

	assign ready_recieve_pixel = (state == RECEIVE);
	assign accept              = end_recieve_pixel && (state == RECEIVE);
	assign last_col            = (col_cnt == COL_W'(IMG_WIDTH - 1));
	assign last_row            = (row_cnt == ROW_W'(IMG_HEIGHT - 1));
	assign blk_x               = col_cnt[BLK_W-1:0];    // position inside the block
	assign blk_y               = row_cnt[BLK_W-1:0];
	assign first_in_block      = (blk_x == '0) && (blk_y == '0);
	assign last_in_block       = (blk_x == BLK_W'(BLOCK_SIZE - 1)) &&
	                             (blk_y == BLK_W'(BLOCK_SIZE - 1));

	//////////////////////////////////////////////////
	// raster position and FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (trig_reset)
		begin
			col_cnt <= '0;
			row_cnt <= '0;
		end
		else if (accept)
		begin
			if (last_col)
			begin
				col_cnt <= '0;
				row_cnt <= last_row ? '0 : row_cnt + 1'b1;    // wrap at end of frame
			end
			else
			begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (trig_reset)
		begin
			state     <= IDLE;
			flush_cnt <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					state <= RECEIVE;
				end
				RECEIVE:
				begin
					flush_cnt <= '0;
					if (accept && last_col && last_row)
						state <= FRAME_FLUSH;
				end
				FRAME_FLUSH:
				begin
					if (flush_cnt == 2'(FLUSH_CYCLES - 1))
						state <= RECEIVE;    // final result is out this cycle
					else
						flush_cnt <= flush_cnt + 1'b1;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// strobes and registered pixel
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (trig_reset)
		begin
			pixel_strobe <= 1'b0;
			block_start  <= 1'b0;
			block_done   <= 1'b0;
			frame_done   <= 1'b0;
		end
		else
		begin
			pixel_strobe <= accept;
			block_start  <= accept && first_in_block;
			block_done   <= accept && last_in_block;
			frame_done   <= accept && last_col && last_row;    // rides with the last block_done
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			pixel_d    <= pixel;
			block_col  <= block_coord_t'(col_cnt >> BLK_W);
			block_row  <= block_coord_t'(row_cnt >> BLK_W);
			lower_half <= (blk_y >= BLK_W'(BLOCK_SIZE / 2));    // rows 2 and 3
		end
	end

	// host must only strobe while ready is shown
	a_accept_needs_ready: assert property (@(posedge clk) disable iff (trig_reset)
		end_recieve_pixel |-> ready_recieve_pixel)
		else $error("pixel strobe seen while intake not ready");

endmodule

/* hdl/block_intensity_sum.sv */
// block intensity accumulator, one running sum per block column
module block_intensity_sum #(
	parameter int IMG_WIDTH = 16
) (
	input  logic                          clk,
	input  logic                          trig_reset,
	input  face_detect_pkg::pixel_t       pixel_d,
	input  logic                          pixel_strobe,
	input  face_detect_pkg::block_coord_t block_col,
	input  logic                          block_start,
	input  logic                          block_done,
	output logic                          sum_valid,
	output face_detect_pkg::block_sum_t   sum_intensity,
	output face_detect_pkg::block_coord_t sum_col
);
	import face_detect_pkg::*;

	localparam int NUM_COLS = IMG_WIDTH / BLOCK_SIZE;
	localparam int IDX_W    = (NUM_COLS > 1) ? $clog2(NUM_COLS) : 1;

	block_sum_t       acc [NUM_COLS];    // partial sum of each block in the current block row
	logic [IDX_W-1:0] col_idx;
	block_sum_t       base;
	block_sum_t       acc_next;

	assign col_idx  = block_col[IDX_W-1:0];
	assign base     = block_start ? '0 : acc[col_idx];    // first pixel restarts the sum
	assign acc_next = base + block_sum_t'(pixel_d);

	always_ff @(posedge clk)
	begin
		if (pixel_strobe)
			acc[col_idx] <= acc_next;
	end

	always_ff @(posedge clk)
	begin
		if (trig_reset)
			sum_valid <= 1'b0;
		else
			sum_valid <= block_done;
	end

	// completed sum includes the pixel arriving with block_done
	always_ff @(posedge clk)
	begin
		if (block_done)
		begin
			sum_intensity <= acc_next;
			sum_col       <= block_col;
		end
	end

endmodule

/* hdl/block_edge_sum.sv */
// haar-like edge accumulator, bottom two rows minus top two rows per block
module block_edge_sum #(
	parameter int IMG_WIDTH = 16
) (
	input  logic                          clk,
	input  logic                          trig_reset,
	input  face_detect_pkg::pixel_t       pixel_d,
	input  logic                          pixel_strobe,
	input  face_detect_pkg::block_coord_t block_col,
	input  logic                          lower_half,
	input  logic                          block_start,
	input  logic                          block_done,
	output logic                          edge_valid,
	output face_detect_pkg::edge_diff_t   edge_value
);
	import face_detect_pkg::*;

	localparam int NUM_COLS = IMG_WIDTH / BLOCK_SIZE;
	localparam int IDX_W    = (NUM_COLS > 1) ? $clog2(NUM_COLS) : 1;

	edge_diff_t       acc [NUM_COLS];
	logic [IDX_W-1:0] col_idx;
	edge_diff_t       pix_ext;
	edge_diff_t       term;
	edge_diff_t       base;
	edge_diff_t       acc_next;

	assign col_idx  = block_col[IDX_W-1:0];
	assign pix_ext  = edge_diff_t'(pixel_d);             // zero extended, always positive
	assign term     = lower_half ? pix_ext : -pix_ext;   // dark band above gives a positive value
	assign base     = block_start ? '0 : acc[col_idx];
	assign acc_next = base + term;

	//////////////////////////////////////////////////
	// per-column signed accumulation
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (pixel_strobe)
			acc[col_idx] <= acc_next;
	end

	always_ff @(posedge clk)
	begin
		if (trig_reset)
			edge_valid <= 1'b0;
		else
			edge_valid <= block_done;    // same stage as the intensity sum
	end

	always_ff @(posedge clk)
	begin
		if (block_done)
			edge_value <= acc_next;
	end

endmodule

/* hdl/face_candidate_classifier.sv */
// face candidate classifier, contrast test per block and per-frame candidate count
module face_candidate_classifier #(
	parameter int CONTRAST_SHIFT = 3
) (
	input  logic                          clk,
	input  logic                          trig_reset,
	input  logic                          sum_valid,
	input  face_detect_pkg::block_sum_t   sum_intensity,
	input  face_detect_pkg::block_coord_t sum_col,
	input  logic                          edge_valid,
	input  face_detect_pkg::edge_diff_t   edge_value,
	input  face_detect_pkg::block_coord_t block_row,
	input  logic                          frame_done,
	output logic                          block_valid,
	output face_detect_pkg::block_coord_t block_x,
	output face_detect_pkg::block_coord_t block_y,
	output logic                          block_face,
	output face_detect_pkg::block_sum_t   block_intensity,
	output face_detect_pkg::face_count_t  face_count,
	output logic                          end_frame
);
	import face_detect_pkg::*;

	edge_diff_t   threshold;
	block_coord_t row_d;          // row index lined up with the sum stage
	logic         frame_done_d;
	logic         is_face;
	logic         first_block;

	assign threshold   = edge_diff_t'(sum_intensity >> CONTRAST_SHIFT);
	assign is_face     = (edge_value > threshold);    // signed compare
	assign first_block = (sum_col == '0) && (row_d == '0);

	always_ff @(posedge clk)
	begin
		if (trig_reset)
		begin
			block_valid  <= 1'b0;
			frame_done_d <= 1'b0;
			end_frame    <= 1'b0;
			face_count   <= '0;
		end
		else
		begin
			block_valid  <= sum_valid && edge_valid;
			frame_done_d <= frame_done;
			end_frame    <= frame_done_d;    // lands with the final block_valid
			if (sum_valid)
			begin
				if (first_block)
					face_count <= face_count_t'(is_face);    // new frame starts the count
				else
					face_count <= face_count + face_count_t'(is_face);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		row_d <= block_row;
		if (sum_valid)
		begin
			block_x         <= sum_col;
			block_y         <= row_d;
			block_face      <= is_face;
			block_intensity <= sum_intensity;
		end
	end

	// both sum units run in lockstep off the same intake strobes
	a_sums_lockstep: assert property (@(posedge clk) disable iff (trig_reset)
		sum_valid == edge_valid)
		else $error("intensity and edge results out of step");

endmodule

/* hdl/facial_detection_ip.sv */
// face candidate detector top, intake feeding two block sum units and a classifier
module facial_detection_ip #(
	parameter int IMG_WIDTH      = 16,
	parameter int IMG_HEIGHT     = 16,
	parameter int CONTRAST_SHIFT = 3
) (
	input  logic                          clk,
	input  logic                          trig_reset,
	input  face_detect_pkg::pixel_t       pixel,
	input  logic                          end_recieve_pixel,
	output logic                          ready_recieve_pixel,
	output logic                          block_valid,
	output face_detect_pkg::block_coord_t block_x,
	output face_detect_pkg::block_coord_t block_y,
	output logic                          block_face,
	output face_detect_pkg::block_sum_t   block_intensity,
	output face_detect_pkg::face_count_t  face_count,
	output logic                          end_frame
);
	import face_detect_pkg::*;

	pixel_t       pixel_d;
	logic         pixel_strobe;
	block_coord_t block_col;
	block_coord_t block_row;
	logic         lower_half;
	logic         block_start;
	logic         block_done;
	logic         frame_done;
	logic         sum_valid;
	block_sum_t   sum_intensity;
	block_coord_t sum_col;
	logic         edge_valid;
	edge_diff_t   edge_value;

	//////////////////////////////////////////////////
	// intake
	//////////////////////////////////////////////////

	pixel_intake #(
		.IMG_WIDTH  (IMG_WIDTH),
		.IMG_HEIGHT (IMG_HEIGHT)
	) pixel_intake0 (
		.clk                 (clk),
		.trig_reset          (trig_reset),
		.pixel               (pixel),
		.end_recieve_pixel   (end_recieve_pixel),
		.ready_recieve_pixel (ready_recieve_pixel),
		.pixel_d             (pixel_d),
		.pixel_strobe        (pixel_strobe),
		.block_col           (block_col),
		.block_row           (block_row),
		.lower_half          (lower_half),
		.block_start         (block_start),
		.block_done          (block_done),
		.frame_done          (frame_done)
	);

	//////////////////////////////////////////////////
	// parallel block sums
	//////////////////////////////////////////////////

	block_intensity_sum #(
		.IMG_WIDTH (IMG_WIDTH)
	) block_intensity_sum0 (
		.clk           (clk),
		.trig_reset    (trig_reset),
		.pixel_d       (pixel_d),
		.pixel_strobe  (pixel_strobe),
		.block_col     (block_col),
		.block_start   (block_start),
		.block_done    (block_done),
		.sum_valid     (sum_valid),
		.sum_intensity (sum_intensity),
		.sum_col       (sum_col)
	);

	block_edge_sum #(
		.IMG_WIDTH (IMG_WIDTH)
	) block_edge_sum0 (
		.clk          (clk),
		.trig_reset   (trig_reset),
		.pixel_d      (pixel_d),
		.pixel_strobe (pixel_strobe),
		.block_col    (block_col),
		.lower_half   (lower_half),
		.block_start  (block_start),
		.block_done   (block_done),
		.edge_valid   (edge_valid),
		.edge_value   (edge_value)
	);

	//////////////////////////////////////////////////
	// classifier
	//////////////////////////////////////////////////

	face_candidate_classifier #(
		.CONTRAST_SHIFT (CONTRAST_SHIFT)
	) face_candidate_classifier0 (
		.clk             (clk),
		.trig_reset      (trig_reset),
		.sum_valid       (sum_valid),
		.sum_intensity   (sum_intensity),
		.sum_col         (sum_col),
		.edge_valid      (edge_valid),
		.edge_value      (edge_value),
		.block_row       (block_row),
		.frame_done      (frame_done),
		.block_valid     (block_valid),
		.block_x         (block_x),
		.block_y         (block_y),
		.block_face      (block_face),
		.block_intensity (block_intensity),
		.face_count      (face_count),
		.end_frame       (end_frame)
	);

endmodule

/* verification/tb_facial_detection_ip.sv */
// testbench for the face candidate detector, directed frames checked against a block model
module tb_facial_detection_ip;
	timeunit 1ns;
	timeprecision 1ns;
	import face_detect_pkg::*;

	localparam int IMG_W          = 16;
	localparam int IMG_H          = 16;
	localparam int SHIFT          = 3;
	localparam int MAX_GAP        = 3;    // idle cycles before a paced strobe
	localparam int LATENCY        = 3;
	// five frames at up to (MAX_GAP + 1) cycles per pixel, plus reset and margin
	localparam int TIMEOUT_CYCLES = 5 * IMG_W * IMG_H * (MAX_GAP + 1) + 880;

	logic         clk;
	logic         trig_reset;
	pixel_t       pixel;
	logic         end_recieve_pixel;
	logic         ready_recieve_pixel;
	logic         block_valid;
	block_coord_t block_x;
	block_coord_t block_y;
	logic         block_face;
	block_sum_t   block_intensity;
	face_count_t  face_count;
	logic         end_frame;

	pixel_t       img [IMG_H][IMG_W];    // frame being sent
	block_coord_t exp_x [$];
	block_coord_t exp_y [$];
	block_sum_t   exp_sum [$];
	bit           exp_face [$];
	face_count_t  exp_count [$];         // one entry per frame
	int           done_cycle [$];        // cycle of each block's last pixel
	int           cycle_cnt;
	int           error_count;
	int           seed;

	facial_detection_ip dut0 (.*);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	//////////////////////////////////////////////////
	// checking
	//////////////////////////////////////////////////

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_mismatch(input string msg);
		error_count++;
		$display("Fail at %0t ns: %s", $time, msg);
		abort_run();
	endtask

	task automatic compare_intensity(input block_sum_t got, input block_sum_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
	endtask

	task automatic compare_coord(input block_coord_t got, input block_coord_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
	endtask

	task automatic compare_flag(input bit got, input bit exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s is %0b, expected %0b", what, got, exp));
	endtask

	task automatic compare_count(input face_count_t got, input face_count_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
	endtask

	task automatic compare_latency(input int got, input int exp, input string what);
		if (got != exp)
			report_mismatch($sformatf("%s is %0d cycles, expected %0d", what, got, exp));
	endtask

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	function automatic int model_intensity(input int bx, input int by);
		int total;
		total = 0;
		for (int r = 0; r < BLOCK_SIZE; r++)
			for (int c = 0; c < BLOCK_SIZE; c++)
				total += img[by * BLOCK_SIZE + r][bx * BLOCK_SIZE + c];
		return total;
	endfunction

	function automatic int model_edge(input int bx, input int by);
		int diff;
		diff = 0;
		for (int r = 0; r < BLOCK_SIZE; r++)
			for (int c = 0; c < BLOCK_SIZE; c++)
				if (r >= 2)
					diff += img[by * BLOCK_SIZE + r][bx * BLOCK_SIZE + c];    // cheek rows
				else
					diff -= img[by * BLOCK_SIZE + r][bx * BLOCK_SIZE + c];
		return diff;
	endfunction

	// blocks finish in raster block order
	task automatic push_expected();
		int faces;
		bit face;
		faces = 0;
		for (int by = 0; by < IMG_H / BLOCK_SIZE; by++)
			for (int bx = 0; bx < IMG_W / BLOCK_SIZE; bx++)
			begin
				face = model_edge(bx, by) > (model_intensity(bx, by) >> SHIFT);
				exp_x.push_back(block_coord_t'(bx));
				exp_y.push_back(block_coord_t'(by));
				exp_sum.push_back(block_sum_t'(model_intensity(bx, by)));
				exp_face.push_back(face);
				faces += face;
			end
		exp_count.push_back(face_count_t'(faces));
	endtask

	always @(negedge clk)
	begin
		bit last_block;
		if (!trig_reset)
		begin
			if (end_frame && !block_valid)
			begin
				$display("end_frame was raised without a block result");
				abort_run();
			end
			if (block_valid && exp_x.size() == 0)
			begin
				$display("a block result came out when no block was pending");
				abort_run();
			end
			else if (block_valid)
			begin
				last_block = (exp_x[0] == IMG_W / BLOCK_SIZE - 1) &&
				             (exp_y[0] == IMG_H / BLOCK_SIZE - 1);
				compare_coord(block_x, exp_x.pop_front(), "block_x");
				compare_coord(block_y, exp_y.pop_front(), "block_y");
				compare_intensity(block_intensity, exp_sum.pop_front(), "block_intensity");
				compare_flag(block_face, exp_face.pop_front(), "block_face");
				compare_latency(cycle_cnt - done_cycle.pop_front(), LATENCY, "block latency");
				compare_flag(end_frame, last_block, "end_frame");
				if (last_block)
					compare_count(face_count, exp_count.pop_front(), "face_count at end_frame");
			end
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	task automatic send_frame(input bit gapped);
		int gap;
		push_expected();
		for (int y = 0; y < IMG_H; y++)
			for (int x = 0; x < IMG_W; x++)
			begin
				gap = gapped ? $unsigned($random(seed)) % (MAX_GAP + 1) : 0;
				end_recieve_pixel = 1'b0;
				repeat (gap) @(negedge clk);
				while (!ready_recieve_pixel)
					@(negedge clk);
				pixel             = img[y][x];
				end_recieve_pixel = 1'b1;
				if ((x % BLOCK_SIZE == BLOCK_SIZE - 1) && (y % BLOCK_SIZE == BLOCK_SIZE - 1))
					done_cycle.push_back(cycle_cnt);    // block completes with this pixel
				@(negedge clk);
			end
		end_recieve_pixel = 1'b0;
		for (int i = 0; i < LATENCY; i++)
		begin
			compare_flag(ready_recieve_pixel, 1'b0, "ready during frame flush");
			@(negedge clk);
		end
		compare_flag(ready_recieve_pixel, 1'b1, "ready after frame flush");
	endtask

	task automatic fill_random();
		for (int y = 0; y < IMG_H; y++)
			for (int x = 0; x < IMG_W; x++)
				img[y][x] = pixel_t'($random(seed));
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic test_reset();
		trig_reset = 1'b1;
		for (int i = 0; i < 5; i++)
		begin
			@(negedge clk);
			compare_flag(ready_recieve_pixel, 1'b0, "ready in reset");
			compare_flag(block_valid, 1'b0, "block_valid in reset");
			compare_flag(end_frame, 1'b0, "end_frame in reset");
		end
		compare_count(face_count, '0, "face_count after reset");
		trig_reset = 1'b0;
		@(negedge clk);
		compare_flag(ready_recieve_pixel, 1'b1, "ready one cycle after reset release");
	endtask

	task automatic test_uniform_frame();
		for (int y = 0; y < IMG_H; y++)
			for (int x = 0; x < IMG_W; x++)
				img[y][x] = 12'd1234;
		send_frame(1'b0);
		compare_count(face_count, '0, "face_count of uniform frame");
	endtask

	task automatic test_dark_band_frame();
		for (int y = 0; y < IMG_H; y++)
			for (int x = 0; x < IMG_W; x++)
				img[y][x] = (y % BLOCK_SIZE < 2) ? 12'd100 : 12'd3000;    // eye band on top
		send_frame(1'b0);
		compare_count(face_count, 16'd16, "face_count of dark band frame");
	endtask

	task automatic test_random_frame();
		fill_random();
		send_frame(1'b0);
	endtask

	task automatic test_paced_frames();
		fill_random();
		send_frame(1'b1);
		fill_random();
		send_frame(1'b1);    // starts as soon as ready returns
	endtask

	initial
	begin
		clk               = 1'b0;
		trig_reset        = 1'b1;
		pixel             = '0;
		end_recieve_pixel = 1'b0;
		cycle_cnt         = 0;
		error_count       = 0;
		seed              = 32'hfc97;
		test_reset();
		test_uniform_frame();
		test_dark_band_frame();
		test_random_frame();
		test_paced_frames();
		if (exp_x.size() != 0)
		begin
			$display("%0d block results never came out", exp_x.size());
			error_count++;
		end
		if (error_count == 0)
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
		else
		begin
			abort_run();
		end
	end

endmodule

/* flist.f */
hdl/face_detect_pkg.sv
hdl/pixel_intake.sv
hdl/block_intensity_sum.sv
hdl/block_edge_sum.sv
hdl/face_candidate_classifier.sv
hdl/facial_detection_ip.sv
verification/tb_facial_detection_ip.sv

/* run_sim.sh */
#!/bin/sh
# build and run the face detector testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_facial_detection_ip \
	-f flist.f -o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1
grep -q "ALL CHECKS PASSED" sim.log \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }
